/* filelist.f */
+incdir+design
design/surfturf_pkg.sv
design/turf_cmd_link.sv
design/surfturf_regs.sv
design/cmd_splice.sv
design/surf_channel.sv
design/surfturf_wrapper.sv
test/surfturf_asserts.sv
test/surfturf_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= surfturf_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/surfturf_tb.sv */
`timescale 1ns/1ps
`include "surfturf_defs.svh"

module surfturf_tb import surfturf_pkg::*; ();

    localparam int NCH = `ST_NUM_SURF;
    localparam logic [3:0] OP_WR    = 4'd0;
    localparam logic [3:0] OP_RD    = 4'd1;
    localparam logic [3:0] OP_TURF  = 4'd2;
    localparam logic [3:0] OP_READY = 4'd3;
    localparam logic [3:0] OP_BYTES = 4'd4;
    localparam logic [3:0] OP_DRAIN = 4'd5;
    localparam bus_data_t  RESP_WORD = 32'h5EED0042;

    typedef struct packed {
        logic [3:0] op;
        bus_addr_t  adr;
        bus_data_t  data;
        bus_data_t  exp;
    } step_t;

    logic                     sysclk;
    logic                     rst_n;
    bus_req_t                 bus_req;
    bus_rsp_t                 bus_rsp;
    cmd_word_t                turf_word;
    logic                     turf_valid;
    logic                     locked;
    cmd_word_t                command;
    logic                     command_valid;
    bus_data_t                response;
    byte_t        [NCH-1:0]   surf_byte;
    logic         [NCH-1:0]   surf_valid;
    stream_beat_t [NCH-1:0]   m_beat;
    logic         [NCH-1:0]   m_valid;
    logic         [NCH-1:0]   m_ready;

    step_t        steps [$];
    stream_beat_t exp_q [NCH][$];
    int           window [NCH];
    logic [NCH-1:0] mask;
    logic [31:0]  lcg;
    bus_data_t    rdat;
    stream_beat_t want;
    int           cycles;
    int           limit;

    surfturf_wrapper surfturf_wrapper_inst (
        .sysclk_i          (sysclk),
        .rst_n_i           (rst_n),
        .bus_req_i         (bus_req),
        .bus_rsp_o         (bus_rsp),
        .turf_word_i       (turf_word),
        .turf_word_valid_i (turf_valid),
        .command_locked_o  (locked),
        .command_o         (command),
        .command_valid_o   (command_valid),
        .response_i        (response),
        .surf_byte_i       (surf_byte),
        .surf_valid_i      (surf_valid),
        .m_beat_o          (m_beat),
        .m_valid_o         (m_valid),
        .m_ready_i         (m_ready)
    );

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            stop_failed($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_step(input logic [3:0] op, input bus_addr_t adr, input bus_data_t data,
                            input bus_data_t exp);
        steps.push_back({op, adr, data, exp});
    endtask

    // one request with its ack expected on the next falling edge
    task automatic bus_access(input logic we, input bus_addr_t adr, input bus_data_t wdat,
                              output bus_data_t rd);
        int waited;
        waited = 0;
        bus_req = '{stb: 1'b1, we: we, adr: adr, wdat: wdat};
        @(negedge sysclk);
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
        while (!bus_rsp.ack) begin
            if (waited == 4) begin
                stop_failed($sformatf("no bus ack for address 0x%h", adr));
            end
            waited++;
            @(negedge sysclk);
        end
        rd = bus_rsp.rdat;
    endtask

    // model side effects of control core writes
    task automatic bus_write(input bus_addr_t adr, input bus_data_t data);
        bus_data_t unused;
        if (adr == 12'h804) begin
            mask = data[NCH-1:0];
        end
        if (adr == 12'h80C) begin
            for (int c = 0; c < NCH; c++) begin
                if (!mask[c] && window[c] == 0) begin
                    window[c] = `ST_EVENT_LEN;
                end
            end
        end
        if (adr == 12'h800 && data[0]) begin
            for (int c = 0; c < NCH; c++) begin
                window[c] = 0;
                exp_q[c].delete();
            end
        end
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic send_turf(input bus_data_t word, input bus_data_t fwd);
        int waited;
        waited = 0;
        turf_word  = word;
        turf_valid = 1'b1;
        @(negedge sysclk);
        turf_valid = 1'b0;
        while (!command_valid && waited < 4) begin
            @(negedge sysclk);
            waited++;
        end
        check_value("command_valid_o", 32'(command_valid), fwd);
        if (command_valid) begin
            check_value("command_o", command, word);
            @(negedge sysclk);
            // the pulse lasts one cycle
            check_value("command_valid_o", 32'(command_valid), 32'h0);
        end
    endtask

    task automatic send_bytes(input int count);
        stream_beat_t beat;
        // trigger needs a few cycles to reach the channels
        repeat (4) @(negedge sysclk);
        for (int n = 0; n < count; n++) begin
            for (int c = 0; c < NCH; c++) begin
                lcg = lcg_next(lcg);
                surf_byte[c] = lcg[23:16];
                if (window[c] > 0) begin
                    beat.tdata = lcg[23:16];
                    beat.tlast = (window[c] == 1);
                    if (exp_q[c].size() < `ST_FIFO_DEPTH) begin
                        exp_q[c].push_back(beat);
                    end
                    window[c]--;
                end
            end
            surf_valid = '1;
            @(negedge sysclk);
        end
        surf_valid = '0;
    endtask

    task automatic wait_drained();
        int busy;
        busy = 1;
        while (busy != 0) begin
            @(negedge sysclk);
            busy = 0;
            for (int c = 0; c < NCH; c++) begin
                if (m_ready[c] && exp_q[c].size() != 0) begin
                    busy = 1;
                end
            end
        end
        @(negedge sysclk);
        check_value("m_valid_o", 32'(m_valid & m_ready), 32'h0);
    endtask

    // output beats leave on the rising edge with valid and ready
    always @(posedge sysclk) begin
        if (rst_n) begin
            for (int c = 0; c < NCH; c++) begin
                if (m_valid[c] && m_ready[c]) begin
                    if (exp_q[c].size() == 0) begin
                        stop_failed($sformatf("channel %0d sent a beat that was not expected", c));
                    end else begin
                        want = exp_q[c].pop_front();
                        check_value($sformatf("m_beat_o[%0d].tdata", c),
                                    32'(m_beat[c].tdata), 32'(want.tdata));
                        check_value($sformatf("m_beat_o[%0d].tlast", c),
                                    32'(m_beat[c].tlast), 32'(want.tlast));
                    end
                end
            end
        end
    end

    always @(posedge sysclk) begin
        cycles++;
        if (cycles > limit) begin
            stop_failed($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
    end

    initial begin
        rst_n      = 1'b0;
        bus_req    = '0;
        turf_word  = '0;
        turf_valid = 1'b0;
        response   = RESP_WORD;
        surf_byte  = '0;
        surf_valid = '0;
        m_ready    = '1;
        mask       = '0;
        lcg        = 32'd71116;
        cycles     = 0;
        for (int c = 0; c < NCH; c++) begin
            window[c] = 0;
        end

        // lock and forwarding
        add_step(OP_RD,    12'h000, 32'h0,           32'h0);
        add_step(OP_TURF,  12'h000, 32'h00001234,    32'h0);
        add_step(OP_TURF,  12'h000, `ST_TRAIN_WORD,  32'h0);
        add_step(OP_RD,    12'h000, 32'h0,           32'h0);
        add_step(OP_TURF,  12'h000, `ST_TRAIN_WORD,  32'h0);
        add_step(OP_RD,    12'h000, 32'h0,           32'h1);
        add_step(OP_TURF,  12'h000, 32'h00010005,    32'h1);
        add_step(OP_TURF,  12'h000, 32'h7FFF0002,    32'h1);
        add_step(OP_TURF,  12'h000, `ST_TRAIN_WORD,  32'h0);
        add_step(OP_RD,    12'h004, 32'h0,           32'h2);
        add_step(OP_RD,    12'h00C, 32'h0,           RESP_WORD);
        add_step(OP_WR,    12'h000, 32'h0,           32'h0);
        add_step(OP_RD,    12'h000, 32'h0,           32'h0);
        add_step(OP_TURF,  12'h000, 32'h00000001,    32'h0);
        // local trigger
        add_step(OP_WR,    12'h80C, 32'h00000123,    32'h0);
        add_step(OP_BYTES, 12'h000, 32'd10,          32'h0);
        add_step(OP_DRAIN, 12'h000, 32'h0,           32'h0);
        add_step(OP_RD,    12'h810, 32'h0,           32'h1);
        // back-pressure on channel 2
        add_step(OP_READY, 12'h000, 32'h3B,          32'h0);
        add_step(OP_WR,    12'h80C, 32'h00000200,    32'h0);
        add_step(OP_BYTES, 12'h000, 32'd8,           32'h0);
        add_step(OP_WR,    12'h80C, 32'h00000300,    32'h0);
        add_step(OP_BYTES, 12'h000, 32'd8,           32'h0);
        add_step(OP_WR,    12'h80C, 32'h00000400,    32'h0);
        add_step(OP_BYTES, 12'h000, 32'd9,           32'h0);
        add_step(OP_DRAIN, 12'h000, 32'h0,           32'h0);
        add_step(OP_RD,    12'h0C8, 32'h0,           32'd16);
        add_step(OP_RD,    12'h0C4, 32'h0,           32'd8);
        add_step(OP_READY, 12'h000, 32'h3F,          32'h0);
        add_step(OP_DRAIN, 12'h000, 32'h0,           32'h0);
        // disable channel 1 and then event reset
        add_step(OP_WR,    12'h804, 32'h02,          32'h0);
        add_step(OP_WR,    12'h80C, 32'h00000500,    32'h0);
        add_step(OP_BYTES, 12'h000, 32'd8,           32'h0);
        add_step(OP_DRAIN, 12'h000, 32'h0,           32'h0);
        add_step(OP_RD,    12'h080, 32'h0,           32'd4);
        add_step(OP_RD,    12'h040, 32'h0,           32'd5);
        add_step(OP_WR,    12'h800, 32'h1,           32'h0);
        add_step(OP_RD,    12'h1C0, 32'h0,           32'h0);
        add_step(OP_RD,    12'h0C4, 32'h0,           32'h0);
        add_step(OP_RD,    12'h080, 32'h0,           32'h0);
        limit = steps.size() * 64;

        repeat (2) @(negedge sysclk);
        rst_n = 1'b1;

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WR:    bus_write(steps[i].adr, steps[i].data);
                OP_RD: begin
                    bus_access(1'b0, steps[i].adr, 32'h0, rdat);
                    check_value($sformatf("bus_rsp_o.rdat at 0x%h", steps[i].adr),
                                rdat, steps[i].exp);
                    // the lock output follows the lock bit of slot 0 register 0
                    if (steps[i].adr == 12'h000) begin
                        check_value("command_locked_o", 32'(locked), steps[i].exp);
                    end
                end
                OP_TURF:  send_turf(steps[i].data, steps[i].exp);
                OP_READY: m_ready = steps[i].data[NCH-1:0];
                OP_BYTES: send_bytes(int'(steps[i].data));
                OP_DRAIN: wait_drained();
                default:  stop_failed("unknown operation in the stimulus table");
            endcase
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* test/surfturf_asserts.sv */
`timescale 1ns/1ps
`include "surfturf_defs.svh"

module surfturf_asserts import surfturf_pkg::*; (
    input logic                               sysclk_i,
    input logic                               rst_n_i,
    input bus_req_t                           bus_req_i,
    input bus_rsp_t                           bus_rsp_o,
    input logic                               command_locked_o,
    input logic                               command_valid_o,
    input stream_beat_t [`ST_NUM_SURF-1:0]    m_beat_o,
    input logic         [`ST_NUM_SURF-1:0]    m_valid_o,
    input logic         [`ST_NUM_SURF-1:0]    m_ready_i
);

    // every strobe is acked exactly one cycle later
    ack_after_stb: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        bus_req_i.stb |=> bus_rsp_o.ack)
        else $error("bus ack missing one cycle after stb");

    no_stray_ack: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
        !bus_req_i.stb |=> !bus_rsp_o.ack)
        else $error("bus ack without a request");

    valids_low_in_reset: assert property (@(posedge sysclk_i)
        !rst_n_i |=> (m_valid_o == '0) && !command_valid_o && !command_locked_o)
        else $error("valid or lock high while in reset");

    for (genvar i = 0; i < `ST_NUM_SURF; i++) begin : g_hold
        beat_held: assert property (@(posedge sysclk_i) disable iff (!rst_n_i)
            m_valid_o[i] && !m_ready_i[i] |=> m_valid_o[i] && $stable(m_beat_o[i]))
            else $error("channel %0d beat changed under back-pressure", i);
    end

endmodule

bind surfturf_wrapper surfturf_asserts u_asserts (
    .sysclk_i         (sysclk_i),
    .rst_n_i          (rst_n_i),
    .bus_req_i        (bus_req_i),
    .bus_rsp_o        (bus_rsp_o),
    .command_locked_o (command_locked_o),
    .command_valid_o  (command_valid_o),
    .m_beat_o         (m_beat_o),
    .m_valid_o        (m_valid_o),
    .m_ready_i        (m_ready_i)
);

/* design/surfturf_wrapper.sv */
`timescale 1ns/1ps
`include "surfturf_defs.svh"

module surfturf_wrapper import surfturf_pkg::*; (
    input  logic                                 sysclk_i,
    input  logic                                 rst_n_i,
    input  bus_req_t                             bus_req_i,
    output bus_rsp_t                             bus_rsp_o,
    input  cmd_word_t                            turf_word_i,
    input  logic                                 turf_word_valid_i,
    output logic                                 command_locked_o,
    output cmd_word_t                            command_o,
    output logic                                 command_valid_o,
    input  bus_data_t                            response_i,
    input  byte_t        [`ST_NUM_SURF-1:0]      surf_byte_i,
    input  logic         [`ST_NUM_SURF-1:0]      surf_valid_i,
    output stream_beat_t [`ST_NUM_SURF-1:0]      m_beat_o,
    output logic         [`ST_NUM_SURF-1:0]      m_valid_o,
    input  logic         [`ST_NUM_SURF-1:0]      m_ready_i
);
    localparam int NSLOT = 8;

    logic                    core_sel;
    logic [NSLOT-1:0]        slot_sel;
    bus_rsp_t                core_rsp;
    bus_rsp_t                slot_rsp [NSLOT];
    bus_addr_t               adr_q;
    logic                    slot7_ack;
    logic                    event_reset;
    logic [`ST_NUM_SURF-1:0] chan_disable;
    logic                    run_valid;
    logic                    run_ready;
    runcmd_t                 run_cmd;
    logic                    trig_valid;
    logic                    trig_ready;
    trig_time_t              trig_time;
    spliced_cmd_t            spliced;

    // bit 11 picks the control core, otherwise bits 8:6 pick a 64-byte slot
    assign core_sel = bus_req_i.adr[11];
    always_comb begin
        for (int k = 0; k < NSLOT; k++) begin
            slot_sel[k] = !bus_req_i.adr[11] && (bus_req_i.adr[8:6] == 3'(k));
        end
    end

    // responses come a cycle later, so steer them with the held address
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            adr_q     <= '0;
            slot7_ack <= 1'b0;
        end else begin
            if (bus_req_i.stb) begin
                adr_q <= bus_req_i.adr;
            end
            slot7_ack <= bus_req_i.stb && slot_sel[7];
        end
    end

    // empty slot still acks
    assign slot_rsp[7].ack  = slot7_ack;
    assign slot_rsp[7].rdat = '0;

    assign bus_rsp_o = adr_q[11] ? core_rsp : slot_rsp[adr_q[8:6]];

    turf_cmd_link u_turf (
        .sysclk_i          (sysclk_i),
        .rst_n_i           (rst_n_i),
        .bus_req_i         (bus_req_i),
        .sel_i             (slot_sel[0]),
        .bus_rsp_o         (slot_rsp[0]),
        .turf_word_i       (turf_word_i),
        .turf_word_valid_i (turf_word_valid_i),
        .response_i        (response_i),
        .command_locked_o  (command_locked_o),
        .command_o         (command_o),
        .command_valid_o   (command_valid_o)
    );

    surfturf_regs u_core (
        .sysclk_i      (sysclk_i),
        .rst_n_i       (rst_n_i),
        .bus_req_i     (bus_req_i),
        .sel_i         (core_sel),
        .bus_rsp_o     (core_rsp),
        .event_reset_o (event_reset),
        .disable_o     (chan_disable),
        .run_valid_o   (run_valid),
        .run_o         (run_cmd),
        .run_ready_i   (run_ready),
        .trig_valid_o  (trig_valid),
        .trig_o        (trig_time),
        .trig_ready_i  (trig_ready)
    );

    cmd_splice u_splice (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .command_i       (command_o),
        .command_valid_i (command_valid_o),
        .run_valid_i     (run_valid),
        .run_i           (run_cmd),
        .run_ready_o     (run_ready),
        .trig_valid_i    (trig_valid),
        .trig_i          (trig_time),
        .trig_ready_o    (trig_ready),
        .spliced_o       (spliced)
    );

    // channel i lives in slot i+1
    for (genvar i = 0; i < `ST_NUM_SURF; i++) begin : g_surf
        surf_channel u_surf (
            .sysclk_i      (sysclk_i),
            .rst_n_i       (rst_n_i),
            .bus_req_i     (bus_req_i),
            .sel_i         (slot_sel[i+1]),
            .bus_rsp_o     (slot_rsp[i+1]),
            .spliced_i     (spliced),
            .event_reset_i (event_reset),
            .disable_i     (chan_disable[i]),
            .surf_byte_i   (surf_byte_i[i]),
            .surf_valid_i  (surf_valid_i[i]),
            .m_beat_o      (m_beat_o[i]),
            .m_valid_o     (m_valid_o[i]),
            .m_ready_i     (m_ready_i[i])
        );
    end

endmodule

/* design/surf_channel.sv */
`timescale 1ns/1ps
`include "surfturf_defs.svh"

module surf_channel import surfturf_pkg::*; (
    input  logic         sysclk_i,
    input  logic         rst_n_i,
    input  bus_req_t     bus_req_i,
    input  logic         sel_i,
    output bus_rsp_t     bus_rsp_o,
    input  spliced_cmd_t spliced_i,
    input  logic         event_reset_i,
    input  logic         disable_i,
    input  byte_t        surf_byte_i,
    input  logic         surf_valid_i,
    output stream_beat_t m_beat_o,
    output logic         m_valid_o,
    input  logic         m_ready_i
);
    localparam int AW = $clog2(`ST_FIFO_DEPTH);
    localparam int CW = $clog2(`ST_EVENT_LEN + 1);

    chan_state_t   state;
    logic [CW-1:0] byte_cnt;
    stream_beat_t  fifo_mem [`ST_FIFO_DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic [AW:0]   level;
    logic          full;
    logic          take;
    logic          push;
    logic          pop;
    logic          last_byte;
    bus_data_t     event_count;
    bus_data_t     drop_count;
    bus_data_t     rd_mux;

    assign level     = wr_ptr - rd_ptr;
    assign full      = (level == (AW + 1)'(`ST_FIFO_DEPTH));
    // bytes inside the window count toward the event even when dropped
    assign take      = (state == CAPTURE) && surf_valid_i;
    assign push      = take && !full;
    assign last_byte = (byte_cnt == CW'(`ST_EVENT_LEN - 1));
    assign m_valid_o = (level != '0);
    assign pop       = m_valid_o && m_ready_i;
    assign m_beat_o  = fifo_mem[rd_ptr[AW-1:0]];

    // DRAIN is a single closing cycle where the event gets tallied
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i || event_reset_i) begin
            state    <= IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    byte_cnt <= '0;
                    if (spliced_i.trig && !disable_i) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (take) begin
                        if (last_byte) begin
                            state <= DRAIN;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                DRAIN:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i || event_reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (push) begin
            fifo_mem[wr_ptr[AW-1:0]] <= {surf_byte_i, last_byte};
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i || event_reset_i) begin
            event_count <= '0;
            drop_count  <= '0;
        end else begin
            if (state == DRAIN) begin
                event_count <= event_count + 1'b1;
            end
            if (take && full) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_comb begin
        case (bus_req_i.adr[5:2])
            4'd0:    rd_mux = event_count;
            4'd1:    rd_mux = drop_count;
            4'd2:    rd_mux = bus_data_t'(level);
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            bus_rsp_o.ack <= 1'b0;
        end else begin
            bus_rsp_o.ack <= bus_req_i.stb && sel_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        bus_rsp_o.rdat <= rd_mux;
    end

endmodule

/* design/cmd_splice.sv */
`timescale 1ns/1ps

module cmd_splice import surfturf_pkg::*; (
    input  logic         sysclk_i,
    input  logic         rst_n_i,
    input  cmd_word_t    command_i,
    input  logic         command_valid_i,
    input  logic         run_valid_i,
    input  runcmd_t      run_i,
    output logic         run_ready_o,
    input  logic         trig_valid_i,
    input  trig_time_t   trig_i,
    output logic         trig_ready_o,
    output spliced_cmd_t spliced_o
);
    spliced_cmd_t next_cmd;

    // turf owns the slot whenever it has a word, locals wait
    assign run_ready_o  = !command_valid_i;
    assign trig_ready_o = !command_valid_i;

    always_comb begin
        next_cmd = '0;
        if (command_valid_i) begin
            next_cmd.trig      = command_i.trig;
            next_cmd.trig_time = command_i.trig_time;
            next_cmd.run_valid = command_i.run_valid;
            next_cmd.runcmd    = command_i.runcmd;
        end else begin
            // both locals can share one spliced word
            if (trig_valid_i) begin
                next_cmd.trig      = 1'b1;
                next_cmd.trig_time = trig_i;
            end
            if (run_valid_i) begin
                next_cmd.run_valid = 1'b1;
                next_cmd.runcmd    = run_i;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            spliced_o <= '0;
        end else begin
            spliced_o <= next_cmd;
        end
    end

endmodule

/* design/surfturf_regs.sv */
`timescale 1ns/1ps
`include "surfturf_defs.svh"

module surfturf_regs import surfturf_pkg::*; (
    input  logic                    sysclk_i,
    input  logic                    rst_n_i,
    input  bus_req_t                bus_req_i,
    input  logic                    sel_i,
    output bus_rsp_t                bus_rsp_o,
    output logic                    event_reset_o,
    output logic [`ST_NUM_SURF-1:0] disable_o,
    output logic                    run_valid_o,
    output runcmd_t                 run_o,
    input  logic                    run_ready_i,
    output logic                    trig_valid_o,
    output trig_time_t              trig_o,
    input  logic                    trig_ready_i
);
    logic       wr;
    logic [3:0] idx;
    bus_data_t  trig_count;
    bus_data_t  rd_mux;

    assign wr  = bus_req_i.stb && sel_i && bus_req_i.we;
    assign idx = bus_req_i.adr[5:2];

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            event_reset_o <= 1'b0;
            disable_o     <= '0;
            run_valid_o   <= 1'b0;
            trig_valid_o  <= 1'b0;
            trig_count    <= '0;
        end else begin
            event_reset_o <= wr && (idx == 4'd0) && bus_req_i.wdat[0];
            if (wr && (idx == 4'd1)) begin
                disable_o <= bus_req_i.wdat[`ST_NUM_SURF-1:0];
            end
            // a new post in the same cycle as a handshake stays pending
            if (run_valid_o && run_ready_i) begin
                run_valid_o <= 1'b0;
            end
            if (wr && (idx == 4'd2)) begin
                run_valid_o <= 1'b1;
            end
            if (trig_valid_o && trig_ready_i) begin
                trig_valid_o <= 1'b0;
                trig_count   <= trig_count + 1'b1;
            end
            if (wr && (idx == 4'd3)) begin
                trig_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (wr && (idx == 4'd2)) begin
            run_o <= bus_req_i.wdat[1:0];
        end
        if (wr && (idx == 4'd3)) begin
            trig_o <= bus_req_i.wdat[14:0];
        end
    end

    // register 0 is write-only, posted items read back as pending flags
    always_comb begin
        case (idx)
            4'd1:    rd_mux = bus_data_t'(disable_o);
            4'd2:    rd_mux = bus_data_t'(run_valid_o);
            4'd3:    rd_mux = bus_data_t'(trig_valid_o);
            4'd4:    rd_mux = trig_count;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            bus_rsp_o.ack <= 1'b0;
        end else begin
            bus_rsp_o.ack <= bus_req_i.stb && sel_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        bus_rsp_o.rdat <= rd_mux;
    end

endmodule

/* design/turf_cmd_link.sv */
`timescale 1ns/1ps
`include "surfturf_defs.svh"

module turf_cmd_link import surfturf_pkg::*; (
    input  logic      sysclk_i,
    input  logic      rst_n_i,
    input  bus_req_t  bus_req_i,
    input  logic      sel_i,
    output bus_rsp_t  bus_rsp_o,
    input  cmd_word_t turf_word_i,
    input  logic      turf_word_valid_i,
    input  bus_data_t response_i,
    output logic      command_locked_o,
    output cmd_word_t command_o,
    output logic      command_valid_o
);
    localparam int LOCK_W = $clog2(`ST_LOCK_COUNT + 1);

    logic [LOCK_W-1:0] train_cnt;
    logic              is_train;
    logic              lock_clear;
    logic              fwd;
    bus_data_t         fwd_count;
    bus_data_t         rd_mux;

    assign is_train   = (turf_word_i == `ST_TRAIN_WORD);
    assign lock_clear = bus_req_i.stb && sel_i && bus_req_i.we && (bus_req_i.adr[5:2] == 4'd0);
    assign fwd        = command_locked_o && turf_word_valid_i && !is_train;

    // any non-training word breaks the run of training words
    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            train_cnt        <= '0;
            command_locked_o <= 1'b0;
        end else if (lock_clear) begin
            train_cnt        <= '0;
            command_locked_o <= 1'b0;
        end else if (turf_word_valid_i && !command_locked_o) begin
            if (!is_train) begin
                train_cnt <= '0;
            end else if (train_cnt == LOCK_W'(`ST_LOCK_COUNT - 1)) begin
                train_cnt        <= '0;
                command_locked_o <= 1'b1;
            end else begin
                train_cnt <= train_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            command_valid_o <= 1'b0;
            fwd_count       <= '0;
        end else begin
            command_valid_o <= fwd;
            if (fwd) begin
                fwd_count <= fwd_count + 1'b1;
            end
        end
    end

    // last forwarded command, also readable as register 2
    always_ff @(posedge sysclk_i) begin
        if (fwd) begin
            command_o <= turf_word_i;
        end
    end

    always_comb begin
        case (bus_req_i.adr[5:2])
            4'd0:    rd_mux = bus_data_t'(command_locked_o);
            4'd1:    rd_mux = fwd_count;
            4'd2:    rd_mux = command_o;
            4'd3:    rd_mux = response_i;
            default: rd_mux = '0;
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_i) begin
            bus_rsp_o.ack <= 1'b0;
        end else begin
            bus_rsp_o.ack <= bus_req_i.stb && sel_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        bus_rsp_o.rdat <= rd_mux;
    end

endmodule

/* design/surfturf_pkg.sv */
package surfturf_pkg;

    typedef logic [11:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [14:0] trig_time_t;
    typedef logic [1:0]  runcmd_t;
    typedef logic [7:0]  byte_t;

    // register bus request, one-cycle strobe
    typedef struct packed {
        logic      stb;
        logic      we;
        bus_addr_t adr;
        bus_data_t wdat;
    } bus_req_t;

    typedef struct packed {
        logic      ack;
        bus_data_t rdat;
    } bus_rsp_t;

    // turf command word layout
    typedef struct packed {
        logic       trig;
        trig_time_t trig_time;
        logic [12:0] rsvd;
        logic       run_valid;
        runcmd_t    runcmd;
    } cmd_word_t;

    // command after merging turf and local sources
    typedef struct packed {
        logic       trig;
        trig_time_t trig_time;
        logic       run_valid;
        runcmd_t    runcmd;
    } spliced_cmd_t;

    typedef struct packed {
        byte_t tdata;
        logic  tlast;
    } stream_beat_t;

    typedef enum logic [1:0] {IDLE, CAPTURE, DRAIN} chan_state_t;

endpackage

/* design/surfturf_defs.svh */
`ifndef SURFTURF_DEFS_SVH
`define SURFTURF_DEFS_SVH

// word the turf link repeats while it is idle or training
`define ST_TRAIN_WORD 32'hA55A6996

// consecutive training words before the link counts as locked
`define ST_LOCK_COUNT 2

// surf channels behind the wrapper, slots 1 to 6
`define ST_NUM_SURF 6

// bytes captured per channel after each trigger
`define ST_EVENT_LEN 8

// per-channel FIFO depth in bytes
// two events fit before bytes start to drop
`define ST_FIFO_DEPTH 16

`endif
